// File: build.f
+incdir+rtl
rtl/cam_pkg.sv
rtl/cam_ctrl.sv
rtl/video_format_regularizer.sv
rtl/video_pixel_packer.sv
rtl/cam_top.sv
testbench/cam_properties.sv
testbench/tb_cam_top.sv

// File: rtl/cam_config.svh
`ifndef CAM_CONFIG_SVH
`define CAM_CONFIG_SVH

// ----------------------------------------------------------------------
//  register bus
// ----------------------------------------------------------------------
`define CAM_WB_ADR_W        8               // word address
`define CAM_WB_DAT_W        32

`define CAM_ID_VALUE        32'h0cab_5219

// region codes live in adr[7:4], register index in adr[3:0]
`define CAM_REGION_GID      4'h0
`define CAM_REGION_FMTR     4'h1

// ----------------------------------------------------------------------
//  video stream
// ----------------------------------------------------------------------
`define CAM_RAW_W           10              // sensor raw pixel
`define CAM_PIX_W           8               // packed pixel
`define CAM_PIX_PER_WORD    4

`define CAM_X_W             16
`define CAM_Y_W             16

// half resolution of the sensor
`define CAM_INIT_WIDTH      1640
`define CAM_INIT_HEIGHT     1232

`endif

// File: rtl/cam_ctrl.sv
`timescale 1ns/100ps
`default_nettype none
`include "cam_config.svh"

module cam_ctrl
    import cam_pkg::*;
(
    input  logic                        axi4s_cam_aclk,
    input  logic                        sys_reset,

    input  wb_req_t                     wb_req_i,
    output logic [`CAM_WB_DAT_W-1:0]    wb_dat_o,
    output logic                        wb_ack_o,

    input  logic                        frame_start_i,
    output fmt_cfg_t                    fmt_cfg_o,
    output logic                        dp_reset_o,
    output logic                        cam_reset_o
);

    // ----------------------------------------------------------------------
    //  address decode
    // ----------------------------------------------------------------------
    logic [3:0]                 region;
    reg_addr_e                  reg_idx;
    logic                       gid_wr;
    logic                       fmtr_wr;

    assign region  = wb_req_i.adr[`CAM_WB_ADR_W-1 -: 4];
    assign reg_idx = reg_addr_e'(wb_req_i.adr[3:0]);

    assign gid_wr  = wb_req_i.stb && wb_req_i.we && (region == `CAM_REGION_GID);
    assign fmtr_wr = wb_req_i.stb && wb_req_i.we && (region == `CAM_REGION_FMTR);

    assign wb_ack_o = wb_req_i.stb;     // zero wait state

    // ----------------------------------------------------------------------
    //  register file
    // ----------------------------------------------------------------------
    logic                       reg_sw_reset;
    logic                       reg_cam_reset;
    logic                       reg_enable;
    logic [`CAM_X_W-1:0]        reg_width;
    logic [`CAM_Y_W-1:0]        reg_height;
    logic [`CAM_RAW_W-1:0]      reg_fill;
    logic [`CAM_WB_DAT_W-1:0]   frame_count;

    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset) begin
            reg_sw_reset  <= 1'b0;
            reg_cam_reset <= 1'b0;
            reg_enable    <= 1'b0;
            reg_width     <= `CAM_X_W'(`CAM_INIT_WIDTH);
            reg_height    <= `CAM_Y_W'(`CAM_INIT_HEIGHT);
            reg_fill      <= '0;
        end else begin
            if (gid_wr) begin
                case (reg_idx)
                    REG_SW_RESET:  reg_sw_reset  <= wb_req_i.dat[0];
                    REG_CAM_RESET: reg_cam_reset <= wb_req_i.dat[0];
                    default: ;
                endcase
            end
            if (fmtr_wr) begin
                case (reg_idx)
                    REG_ENABLE: reg_enable <= wb_req_i.dat[0];
                    REG_WIDTH:  reg_width  <= wb_req_i.dat[`CAM_X_W-1:0];
                    REG_HEIGHT: reg_height <= wb_req_i.dat[`CAM_Y_W-1:0];
                    REG_FILL:   reg_fill   <= wb_req_i.dat[`CAM_RAW_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // datapath reset, one cycle behind the sw bit
    always_ff @(posedge axi4s_cam_aclk) begin
        dp_reset_o <= sys_reset | reg_sw_reset;
    end

    // regularized frames seen
    always_ff @(posedge axi4s_cam_aclk) begin
        if (sys_reset || dp_reset_o) begin
            frame_count <= '0;
        end else if (gid_wr && (reg_idx == REG_FRAME_COUNT)) begin
            frame_count <= wb_req_i.dat;
        end else if (frame_start_i) begin
            frame_count <= frame_count + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    //  read back
    // ----------------------------------------------------------------------
    always_comb begin
        wb_dat_o = '0;      // unmapped reads as zero
        if (region == `CAM_REGION_GID) begin
            case (reg_idx)
                REG_ID:          wb_dat_o = `CAM_ID_VALUE;
                REG_SW_RESET:    wb_dat_o[0] = reg_sw_reset;
                REG_CAM_RESET:   wb_dat_o[0] = reg_cam_reset;
                REG_FRAME_COUNT: wb_dat_o = frame_count;
                default: ;
            endcase
        end else if (region == `CAM_REGION_FMTR) begin
            case (reg_idx)
                REG_ENABLE: wb_dat_o[0] = reg_enable;
                REG_WIDTH:  wb_dat_o[`CAM_X_W-1:0] = reg_width;
                REG_HEIGHT: wb_dat_o[`CAM_Y_W-1:0] = reg_height;
                REG_FILL:   wb_dat_o[`CAM_RAW_W-1:0] = reg_fill;
                default: ;
            endcase
        end
    end

    assign fmt_cfg_o = '{
        enable: reg_enable,
        width:  reg_width,
        height: reg_height,
        fill:   reg_fill
    };

    assign cam_reset_o = reg_cam_reset;

endmodule

`default_nettype wire

// File: rtl/cam_pkg.sv
`include "cam_config.svh"

package cam_pkg;

    // one raw pixel beat, no ready on this stream
    typedef struct packed {
        logic                       valid;
        logic                       user;       // frame start
        logic                       last;       // end of line
        logic [`CAM_RAW_W-1:0]      data;
    } raw_pix_t;

    typedef struct packed {
        logic                       valid;
        logic                       user;
        logic                       last;
        logic [`CAM_PIX_W*`CAM_PIX_PER_WORD-1:0] data;
    } pix_word_t;

    typedef struct packed {
        logic                       stb;
        logic                       we;
        logic [`CAM_WB_ADR_W-1:0]   adr;
        logic [`CAM_WB_DAT_W-1:0]   dat;
    } wb_req_t;

    typedef struct packed {
        logic                       enable;
        logic [`CAM_X_W-1:0]        width;
        logic [`CAM_Y_W-1:0]        height;
        logic [`CAM_RAW_W-1:0]      fill;
    } fmt_cfg_t;

    // index inside a region
    typedef enum logic [3:0] {
        REG_ID          = 4'd0,
        REG_SW_RESET    = 4'd1,
        REG_CAM_RESET   = 4'd2,
        REG_FRAME_COUNT = 4'd3
    } reg_addr_e;

    // the fmtr region shares the same index encoding
    localparam reg_addr_e REG_ENABLE = REG_ID;
    localparam reg_addr_e REG_WIDTH  = REG_SW_RESET;
    localparam reg_addr_e REG_HEIGHT = REG_CAM_RESET;
    localparam reg_addr_e REG_FILL   = REG_FRAME_COUNT;

    typedef enum logic [1:0] {
        ST_WAIT_FRAME,
        ST_LINE,
        ST_PAD,
        ST_SKIP_LINE
    } fmt_state_e;

endpackage

// File: rtl/cam_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "cam_config.svh"

module cam_top
    import cam_pkg::*;
(
    input  logic                        axi4s_cam_aclk,
    input  logic                        sys_reset,

    input  wb_req_t                     wb_req_i,
    output logic [`CAM_WB_DAT_W-1:0]    wb_dat_o,
    output logic                        wb_ack_o,

    input  raw_pix_t                    pix_i,
    output pix_word_t                   word_o,

    output logic                        cam_reset_o
);

    fmt_cfg_t   fmt_cfg;
    logic       dp_reset;
    raw_pix_t   fmtr_pix;       // regularized stream
    logic       frame_start;

    cam_ctrl i_cam_ctrl (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .wb_req_i       (wb_req_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .frame_start_i  (frame_start),
        .fmt_cfg_o      (fmt_cfg),
        .dp_reset_o     (dp_reset),
        .cam_reset_o    (cam_reset_o)
    );

    video_format_regularizer i_video_format_regularizer (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .dp_reset_i     (dp_reset),
        .cfg_i          (fmt_cfg),
        .pix_i          (pix_i),
        .pix_o          (fmtr_pix),
        .frame_start_o  (frame_start)
    );

    // 8 bit x 4 pixels per word
    video_pixel_packer i_video_pixel_packer (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .dp_reset_i     (dp_reset),
        .pix_i          (fmtr_pix),
        .word_o         (word_o)
    );

endmodule

`default_nettype wire

// File: rtl/video_format_regularizer.sv
`timescale 1ns/100ps
`default_nettype none
`include "cam_config.svh"

module video_format_regularizer
    import cam_pkg::*;
(
    input  logic        axi4s_cam_aclk,
    input  logic        dp_reset_i,

    input  fmt_cfg_t    cfg_i,
    input  raw_pix_t    pix_i,

    output raw_pix_t    pix_o,
    output logic        frame_start_o
);

    fmt_state_e                 state;

    logic [`CAM_X_W-1:0]        x_cnt;          // next output column
    logic [`CAM_Y_W-1:0]        y_cnt;

    // settings latched at frame start
    logic [`CAM_X_W-1:0]        cap_width;
    logic [`CAM_Y_W-1:0]        cap_height;
    logic [`CAM_RAW_W-1:0]      cap_fill;

    logic                       start;
    logic                       abort;
    logic                       padding;
    logic                       take_in;
    logic                       emit;
    logic                       line_end;
    logic                       frame_end;

    logic [`CAM_X_W-1:0]        cur_x;
    logic [`CAM_X_W-1:0]        cur_w;
    logic [`CAM_X_W-1:0]        w_last;
    logic [`CAM_Y_W-1:0]        cur_y;
    logic [`CAM_Y_W-1:0]        cur_h;
    logic [`CAM_Y_W-1:0]        h_last;
    logic [`CAM_RAW_W-1:0]      emit_data;

    logic                       out_valid;
    logic                       out_user;
    logic                       out_last;
    logic [`CAM_RAW_W-1:0]      out_data;

    // ----------------------------------------------------------------------
    //  per-cycle decisions
    // ----------------------------------------------------------------------
    assign start   = pix_i.valid && pix_i.user && cfg_i.enable;
    assign abort   = pix_i.valid && pix_i.user && !cfg_i.enable;   // new frame, not taken
    assign padding = (state == ST_PAD) && !start;
    assign take_in = start || ((state == ST_LINE) && pix_i.valid);
    assign emit    = !abort && (take_in || padding);

    // a frame start counts from the live settings and origin
    assign cur_w = start ? cfg_i.width  : cap_width;
    assign cur_h = start ? cfg_i.height : cap_height;
    assign cur_x = start ? '0 : x_cnt;
    assign cur_y = start ? '0 : y_cnt;

    assign w_last    = cur_w - 1'b1;
    assign h_last    = cur_h - 1'b1;
    assign line_end  = (cur_x == w_last);
    assign frame_end = line_end && (cur_y == h_last);

    assign emit_data = padding ? cap_fill : pix_i.data;

    // ----------------------------------------------------------------------
    //  state machine and counters
    // ----------------------------------------------------------------------
    always_ff @(posedge axi4s_cam_aclk) begin
        if (dp_reset_i) begin
            state <= ST_WAIT_FRAME;
            x_cnt <= '0;
            y_cnt <= '0;
        end else if (abort) begin
            state <= ST_WAIT_FRAME;
        end else if (emit) begin
            if (line_end) begin
                x_cnt <= '0;
                y_cnt <= cur_y + 1'b1;
                if (frame_end) begin
                    state <= ST_WAIT_FRAME;     // surplus lines dropped
                end else if (take_in && !pix_i.last) begin
                    state <= ST_SKIP_LINE;      // trim the rest
                end else begin
                    state <= ST_LINE;
                end
            end else begin
                x_cnt <= cur_x + 1'b1;
                y_cnt <= cur_y;
                if (padding || (take_in && pix_i.last)) begin
                    state <= ST_PAD;            // short line
                end else begin
                    state <= ST_LINE;
                end
            end
        end else if ((state == ST_SKIP_LINE) && pix_i.valid && pix_i.last) begin
            state <= ST_LINE;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (start) begin
            cap_width  <= cfg_i.width;
            cap_height <= cfg_i.height;
            cap_fill   <= cfg_i.fill;
        end
    end

    // ----------------------------------------------------------------------
    //  output stage
    // ----------------------------------------------------------------------
    always_ff @(posedge axi4s_cam_aclk) begin
        if (dp_reset_i) begin
            out_valid     <= 1'b0;
            out_user      <= 1'b0;
            out_last      <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            out_valid     <= emit;
            out_user      <= emit && (cur_x == '0) && (cur_y == '0);
            out_last      <= emit && line_end;
            frame_start_o <= start;
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        out_data <= emit_data;
    end

    assign pix_o = '{
        valid: out_valid,
        user:  out_user,
        last:  out_last,
        data:  out_data
    };

endmodule

`default_nettype wire

// File: rtl/video_pixel_packer.sv
`timescale 1ns/100ps
`default_nettype none
`include "cam_config.svh"

module video_pixel_packer
    import cam_pkg::*;
(
    input  logic        axi4s_cam_aclk,
    input  logic        dp_reset_i,

    input  raw_pix_t    pix_i,
    output pix_word_t   word_o
);

    localparam int SLOT_W = $clog2(`CAM_PIX_PER_WORD);

    logic [`CAM_PIX_PER_WORD-1:0][`CAM_PIX_W-1:0]   byte_q;
    logic [`CAM_PIX_PER_WORD-1:0][`CAM_PIX_W-1:0]   byte_next;
    logic [SLOT_W-1:0]                              slot_q;
    logic                                           user_hold;   // user of slot 0

    logic [`CAM_PIX_W-1:0]                          pix8;
    logic                                           word_full;
    logic                                           first_user;

    logic                                           out_valid;
    logic                                           out_user;
    logic                                           out_last;
    logic [`CAM_PIX_W*`CAM_PIX_PER_WORD-1:0]        out_data;

    assign pix8       = pix_i.data[`CAM_RAW_W-1 -: `CAM_PIX_W];    // msbs only
    assign word_full  = (slot_q == SLOT_W'(`CAM_PIX_PER_WORD - 1));
    assign first_user = (slot_q == '0) ? pix_i.user : user_hold;

    // pixel k lands in byte k
    always_comb begin
        byte_next         = byte_q;
        byte_next[slot_q] = pix8;
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (dp_reset_i) begin
            byte_q    <= '0;
            slot_q    <= '0;
            user_hold <= 1'b0;
            out_valid <= 1'b0;
            out_user  <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            out_user  <= 1'b0;
            out_last  <= 1'b0;
            if (pix_i.valid) begin
                if (word_full || pix_i.last) begin
                    out_valid <= 1'b1;
                    out_user  <= first_user;
                    out_last  <= pix_i.last;
                    byte_q    <= '0;        // unfilled bytes go out as zero
                    slot_q    <= '0;
                end else begin
                    byte_q    <= byte_next;
                    slot_q    <= slot_q + 1'b1;
                    user_hold <= first_user;
                end
            end
        end
    end

    always_ff @(posedge axi4s_cam_aclk) begin
        if (pix_i.valid) begin
            out_data <= byte_next;
        end
    end

    assign word_o = '{
        valid: out_valid,
        user:  out_user,
        last:  out_last,
        data:  out_data
    };

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the camera path testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_cam_top \
    -o sim_cam_top

./obj_dir/sim_cam_top > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log
exit 0

// File: testbench/cam_properties.sv
`timescale 1ns/100ps

module cam_properties
    import cam_pkg::*;
(
    input logic         axi4s_cam_aclk,
    input logic         sys_reset,
    input logic         dp_reset_i,
    input wb_req_t      wb_req_i,
    input logic         wb_ack_i,
    input pix_word_t    word_i,
    input raw_pix_t     fmtr_pix_i,
    input logic         frame_start_i
);

    int fail_cnt = 0;       // failed assertions

    // zero wait state bus
    ack_follows_stb: assert property (@(posedge axi4s_cam_aclk)
        wb_ack_i == wb_req_i.stb)
        else begin
            $error("wb ack does not follow the strobe");
            fail_cnt++;
        end

    no_word_after_reset: assert property (@(posedge axi4s_cam_aclk)
        dp_reset_i |=> !word_i.valid)
        else begin
            $error("packed word valid right after datapath reset");
            fail_cnt++;
        end

    flags_need_valid: assert property (@(posedge axi4s_cam_aclk)
        disable iff (sys_reset || dp_reset_i)
        (word_i.user || word_i.last) |-> word_i.valid)
        else begin
            $error("word user or last set without valid");
            fail_cnt++;
        end

    // counter pulse lines up with the first regularized pixel
    frame_start_on_user: assert property (@(posedge axi4s_cam_aclk)
        disable iff (sys_reset || dp_reset_i)
        frame_start_i == (fmtr_pix_i.valid && fmtr_pix_i.user))
        else begin
            $error("frame_start and the regularized user pixel disagree");
            fail_cnt++;
        end

endmodule

bind cam_top cam_properties cam_properties_i (
    .axi4s_cam_aclk (axi4s_cam_aclk),
    .sys_reset      (sys_reset),
    .dp_reset_i     (dp_reset),
    .wb_req_i       (wb_req_i),
    .wb_ack_i       (wb_ack_o),
    .word_i         (word_o),
    .fmtr_pix_i     (fmtr_pix),
    .frame_start_i  (frame_start)
);

// File: testbench/tb_cam_top.sv
`timescale 1ns/100ps
`include "cam_config.svh"

module tb_cam_top
    import cam_pkg::*;
();

    localparam int CLK_PERIOD = 20;

    typedef struct packed {
        int width;
        int height;
        int fill;
        int lines;
        int len;            // input line length
        bit enable;
        bit sw_reset;       // pulse before the frame
    } frame_row_t;

    // exact, short, long plus extra lines, disabled, sw reset, odd width
    frame_row_t rows[$] = '{
        '{8,  3, 'h3ff, 3, 8, 1'b1, 1'b0},
        '{10, 2, 'h155, 2, 5, 1'b1, 1'b0},
        '{6,  2, 'h000, 4, 9, 1'b1, 1'b0},
        '{8,  2, 'h02a, 2, 8, 1'b0, 1'b0},
        '{12, 2, 'h3c0, 2, 7, 1'b1, 1'b1},
        '{5,  3, 'h111, 3, 5, 1'b1, 1'b0}
    };

    logic                       axi4s_cam_aclk;
    logic                       sys_reset;
    wb_req_t                    wb_req;
    logic [`CAM_WB_DAT_W-1:0]   wb_dat;
    logic                       wb_ack;
    raw_pix_t                   pix;
    pix_word_t                  word;
    logic                       cam_reset;

    logic [`CAM_RAW_W-1:0]      pix_q[$];       // input pixels of the current frame
    pix_word_t                  exp_q[$];
    pix_word_t                  got_q[$];
    int                         err_cnt = 0;
    int                         check_cnt = 0;

    cam_top cam_top_i (
        .axi4s_cam_aclk (axi4s_cam_aclk),
        .sys_reset      (sys_reset),
        .wb_req_i       (wb_req),
        .wb_dat_o       (wb_dat),
        .wb_ack_o       (wb_ack),
        .pix_i          (pix),
        .word_o         (word),
        .cam_reset_o    (cam_reset)
    );

    initial begin
        axi4s_cam_aclk = 1'b0;
        forever #(CLK_PERIOD / 2) axi4s_cam_aclk = ~axi4s_cam_aclk;
    end

    always @(negedge axi4s_cam_aclk) begin
        if (word.valid) begin
            got_q.push_back(word);
        end
    end

    initial begin : watchdog
        int limit;
        limit = 200;        // reset and register checks
        foreach (rows[i]) begin
            limit += rows[i].lines * (2 * rows[i].width + 20) + 50;
        end
        repeat (limit) @(posedge axi4s_cam_aclk);
        $display("watchdog expired after %0d cycles, the run did not finish", limit);
        $display("TEST FAILED");
        $finish;
    end

    // ----------------------------------------------------------------------
    //  bus and check helpers
    // ----------------------------------------------------------------------
    task automatic expect_true(input logic ok, input string msg);
        check_cnt++;
        assert (ok) else begin
            err_cnt++;
            $display("[ERROR] %0t: %s", $time, msg);
        end
    endtask

    task automatic bus_write(input logic [`CAM_WB_ADR_W-1:0] adr,
                             input logic [`CAM_WB_DAT_W-1:0] dat);
        @(negedge axi4s_cam_aclk);
        wb_req = '{stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        @(negedge axi4s_cam_aclk);
        wb_req = '0;
    endtask

    task automatic bus_read(input logic [`CAM_WB_ADR_W-1:0] adr,
                            output logic [`CAM_WB_DAT_W-1:0] dat);
        @(negedge axi4s_cam_aclk);
        wb_req = '{stb: 1'b1, we: 1'b0, adr: adr, dat: '0};
        #(CLK_PERIOD / 4);      // mid low phase
        dat = wb_dat;
        expect_true(wb_ack, $sformatf("no ack on read of %h", adr));
        @(negedge axi4s_cam_aclk);
        wb_req = '0;
    endtask

    task automatic check_reg(input logic [`CAM_WB_ADR_W-1:0] adr,
                             input logic [`CAM_WB_DAT_W-1:0] exp);
        logic [`CAM_WB_DAT_W-1:0] rd;
        bus_read(adr, rd);
        expect_true(rd == exp, $sformatf("reg %h read %h, expected %h", adr, rd, exp));
    endtask

    task automatic program_row(input frame_row_t row);
        bus_write({`CAM_REGION_FMTR, REG_WIDTH}, 32'(row.width));
        bus_write({`CAM_REGION_FMTR, REG_HEIGHT}, 32'(row.height));
        bus_write({`CAM_REGION_FMTR, REG_FILL}, 32'(row.fill));
        bus_write({`CAM_REGION_FMTR, REG_ENABLE}, 32'(row.enable));
        check_reg({`CAM_REGION_FMTR, REG_WIDTH}, 32'(row.width));
        check_reg({`CAM_REGION_FMTR, REG_HEIGHT}, 32'(row.height));
        check_reg({`CAM_REGION_FMTR, REG_FILL}, 32'(row.fill));
        check_reg({`CAM_REGION_FMTR, REG_ENABLE}, 32'(row.enable));
    endtask

    // ----------------------------------------------------------------------
    //  reference model and stimulus
    // ----------------------------------------------------------------------
    task automatic build_expected(input frame_row_t row);
        logic [`CAM_RAW_W-1:0]  v;
        logic [31:0]            data;
        logic                   wuser;
        int                     slot;
        int                     r;
        int                     c;
        exp_q.delete();
        data  = '0;
        wuser = 1'b0;
        slot  = 0;
        for (r = 0; row.enable && r < row.lines && r < row.height; r++) begin
            for (c = 0; c < row.width; c++) begin
                v = (c < row.len) ? pix_q[r * row.len + c] : `CAM_RAW_W'(row.fill);
                if (slot == 0)
                    wuser = (r == 0) && (c == 0);
                data = data | (32'(v[9:2]) << (8 * slot));      // little end first
                if (slot == 3 || c == row.width - 1) begin
                    exp_q.push_back('{1'b1, wuser, c == row.width - 1, data});
                    data = '0;
                    slot = 0;
                end else begin
                    slot++;
                end
            end
        end
    endtask

    task automatic send_frame(input frame_row_t row);
        int gap;
        int l;
        int c;
        for (l = 0; l < row.lines; l++) begin
            for (c = 0; c < row.len; c++) begin
                @(negedge axi4s_cam_aclk);
                pix = '{valid: 1'b1, user: (l == 0) && (c == 0),
                        last: (c == row.len - 1), data: pix_q[l * row.len + c]};
            end
            @(negedge axi4s_cam_aclk);
            pix = '0;
            gap = row.width + 2 + int'($urandom % 4);   // longer than any padding
            repeat (gap - 1) @(negedge axi4s_cam_aclk);
        end
    endtask

    // ----------------------------------------------------------------------
    //  main sequence
    // ----------------------------------------------------------------------
    initial begin : main
        int frame_cnt;
        int i;
        int n;
        void'($urandom(32'h8a10));
        frame_cnt = 0;
        sys_reset = 1'b1;
        wb_req    = '0;
        pix       = '0;
        repeat (4) @(negedge axi4s_cam_aclk);
        sys_reset = 1'b0;

        check_reg({`CAM_REGION_GID, REG_ID}, `CAM_ID_VALUE);
        check_reg({`CAM_REGION_FMTR, REG_WIDTH}, `CAM_INIT_WIDTH);
        check_reg({`CAM_REGION_FMTR, REG_HEIGHT}, `CAM_INIT_HEIGHT);
        check_reg({`CAM_REGION_FMTR, REG_ENABLE}, 32'd0);
        expect_true(!cam_reset, "cam_reset_o high after reset");
        bus_write({`CAM_REGION_GID, REG_CAM_RESET}, 32'd1);
        check_reg({`CAM_REGION_GID, REG_CAM_RESET}, 32'd1);
        expect_true(cam_reset, "cam_reset_o did not follow its bit");
        bus_write({`CAM_REGION_GID, REG_CAM_RESET}, 32'd0);
        expect_true(!cam_reset, "cam_reset_o did not clear");
        bus_write({`CAM_REGION_GID, REG_FRAME_COUNT}, 32'h1234_5678);
        check_reg({`CAM_REGION_GID, REG_FRAME_COUNT}, 32'h1234_5678);
        bus_write({`CAM_REGION_GID, REG_FRAME_COUNT}, 32'd0);
        check_reg(8'h17, 32'd0);        // unmapped index
        check_reg(8'h31, 32'd0);        // unmapped region

        for (i = 0; i < rows.size(); i++) begin
            if (rows[i].sw_reset) begin
                bus_write({`CAM_REGION_GID, REG_SW_RESET}, 32'd1);
                check_reg({`CAM_REGION_GID, REG_SW_RESET}, 32'd1);
                bus_write({`CAM_REGION_GID, REG_SW_RESET}, 32'd0);
                frame_cnt = 0;
                check_reg({`CAM_REGION_GID, REG_FRAME_COUNT}, 32'd0);
            end
            program_row(rows[i]);
            pix_q.delete();
            repeat (rows[i].lines * rows[i].len)
                pix_q.push_back(`CAM_RAW_W'($urandom));
            build_expected(rows[i]);
            got_q.delete();
            send_frame(rows[i]);
            for (n = 0; n < 8 && got_q.size() < exp_q.size(); n++)
                @(negedge axi4s_cam_aclk);
            repeat (4) @(negedge axi4s_cam_aclk);  // catch surplus words
            expect_true(got_q.size() == exp_q.size(), $sformatf(
                "row %0d gave %0d words, expected %0d", i, got_q.size(), exp_q.size()));
            foreach (exp_q[k]) begin
                if (k < got_q.size())
                    expect_true(got_q[k] == exp_q[k], $sformatf(
                        "row %0d word %0d is %h, expected %h", i, k, got_q[k], exp_q[k]));
            end
            if (rows[i].enable)
                frame_cnt++;
            check_reg({`CAM_REGION_GID, REG_FRAME_COUNT}, 32'(frame_cnt));
        end

        err_cnt += cam_top_i.cam_properties_i.fail_cnt;
        $display("%0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
